// ==== verilog/isa_pkg.sv ====
// Instruction set definitions
package isa_pkg;

    typedef logic [15:0] word_t;     // Data word
    typedef logic [3:0]  reg_idx_t;  // Register index

    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_NOR   = 4'h3,
        OP_SLL   = 4'h4,
        OP_SRL   = 4'h5,
        OP_SRA   = 4'h6,
        OP_NOP_7 = 4'h7,  // Spare code, treated as NOP
        OP_LW    = 4'h8,
        OP_SW    = 4'h9,
        OP_LHB   = 4'hA,
        OP_LLB   = 4'hB,
        OP_B     = 4'hC,
        OP_CALL  = 4'hD,
        OP_RET   = 4'hE,
        OP_NOP   = 4'hF
    } opcode_e;

    // Special registers
    localparam reg_idx_t DATA_SEG_REG = 4'd14;
    localparam reg_idx_t STACK_REG    = 4'd15;

    // Instruction field positions
    localparam int OPC_MSB  = 15, OPC_LSB  = 12;
    localparam int RD_MSB   = 11, RD_LSB   = 8;   // Also load/store register
    localparam int RS_MSB   = 7,  RS_LSB   = 4;
    localparam int RT_MSB   = 3,  RT_LSB   = 0;   // Also shift immediate
    localparam int IMM8_MSB = 7,  IMM8_LSB = 0;
    localparam int COND_MSB = 10, COND_LSB = 8;
    localparam int TGT_MSB  = 11, TGT_LSB  = 0;

endpackage

// ==== verilog/pipe_pkg.sv ====
// Pipeline control definitions
package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_NOR  = 3'd3,
        ALU_SLL  = 3'd4,
        ALU_SRL  = 3'd5,
        ALU_SRA  = 3'd6,
        ALU_NONE = 3'd7   // Bubble
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_write;
        logic    mem_read;
        logic    mem_to_reg;
        logic    alu_src;       // Immediate as ALU operand B
        alu_op_e alu_op;
        logic    branch;
        logic    call;
        logic    ret;
        logic    load_half;
        logic    half_spec;     // 0 for LHB, 1 for LLB
        logic    data_reg;      // Port 1 reads data segment register
        logic    stack_reg;     // Port 1 reads stack pointer
        logic    rt_src;        // Port 2 index from bits 11 to 8
        logic    sign_ext_sel;  // 8-bit immediate instead of 4-bit
        logic    uses_rs;
        logic    uses_rt;
    } ctrl_t;

    // All off, as in a bubble
    localparam ctrl_t CTRL_NOP = '{alu_op: ALU_NONE, default: 1'b0};

endpackage

// ==== verilog/regfile_if.sv ====
// Register file read interface
`timescale 1ns/1ps

interface regfile_if import isa_pkg::*;;

    reg_idx_t rs_idx;     // Port 1 index from rs field
    reg_idx_t rt_idx;     // Port 2 index
    logic     data_reg;   // Force port 1 to data segment register
    logic     stack_reg;  // Force port 1 to stack pointer
    word_t    rd_data_1;
    word_t    rd_data_2;

    modport reader (
        output rs_idx, rt_idx, data_reg, stack_reg,
        input  rd_data_1, rd_data_2
    );

    modport file (
        input  rs_idx, rt_idx, data_reg, stack_reg,
        output rd_data_1, rd_data_2
    );

endinterface

// ==== verilog/reg_file.sv ====
// Sixteen-entry register file
`timescale 1ns/1ps

module reg_file import isa_pkg::*; #(
    parameter word_t SP_RESET = 16'hFFFF  // Stack pointer after reset
) (
    input  logic     clk,
    input  logic     rst,
    regfile_if.file  rf,
    input  logic     wb_valid,
    input  reg_idx_t wb_reg,
    input  word_t    wb_data
);

    word_t    regs [16];
    reg_idx_t rd_idx_1;

    // Special register selects override rs, stack pointer first
    always_comb begin
        if (rf.stack_reg)
            rd_idx_1 = STACK_REG;
        else if (rf.data_reg)
            rd_idx_1 = DATA_SEG_REG;
        else
            rd_idx_1 = rf.rs_idx;
    end

    // Reads see the value before a same-cycle write
    assign rf.rd_data_1 = regs[rd_idx_1];
    assign rf.rd_data_2 = regs[rf.rt_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= (i == int'(STACK_REG)) ? SP_RESET : '0;  // SP preset
            end
        end else if (wb_valid) begin
            regs[wb_reg] <= wb_data;  // Writeback strobe
        end
    end

endmodule

// ==== verilog/control_decode.sv ====
// Opcode to control decoder
`timescale 1ns/1ps

module control_decode import isa_pkg::*; import pipe_pkg::*; (
    input  opcode_e opcode,
    output ctrl_t   ctrl
);

    always_comb begin
        ctrl = CTRL_NOP;  // Spare codes and NOP fall through
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
                ctrl.reg_write = 1'b1;
                ctrl.uses_rs   = 1'b1;
                ctrl.uses_rt   = 1'b1;
                ctrl.alu_op    = alu_op_e'(opcode[2:0]);  // ALU codes follow opcodes
            end
            OP_SLL, OP_SRL, OP_SRA: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;  // Shift amount from immediate
                ctrl.uses_rs   = 1'b1;
                ctrl.alu_op    = alu_op_e'(opcode[2:0]);
            end
            OP_LW: begin
                ctrl.reg_write    = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.mem_to_reg   = 1'b1;
                ctrl.alu_src      = 1'b1;
                ctrl.data_reg     = 1'b1;  // Base is register 14
                ctrl.sign_ext_sel = 1'b1;
                ctrl.alu_op       = ALU_ADD;
            end
            OP_SW: begin
                ctrl.mem_write    = 1'b1;
                ctrl.alu_src      = 1'b1;
                ctrl.data_reg     = 1'b1;
                ctrl.rt_src       = 1'b1;  // Store data from bits 11 to 8
                ctrl.uses_rt      = 1'b1;
                ctrl.sign_ext_sel = 1'b1;
                ctrl.alu_op       = ALU_ADD;
            end
            OP_LHB, OP_LLB: begin
                ctrl.reg_write    = 1'b1;
                ctrl.load_half    = 1'b1;
                ctrl.half_spec    = (opcode == OP_LLB);
                ctrl.rt_src       = 1'b1;  // Keeps the other half of rd
                ctrl.uses_rt      = 1'b1;
                ctrl.sign_ext_sel = 1'b1;
            end
            OP_B: ctrl.branch = 1'b1;
            OP_CALL: begin
                ctrl.reg_write = 1'b1;
                ctrl.call      = 1'b1;
                ctrl.stack_reg = 1'b1;
                ctrl.uses_rs   = 1'b1;
                ctrl.alu_op    = ALU_SUB;  // Push decrements SP
            end
            OP_RET: begin
                ctrl.reg_write = 1'b1;
                ctrl.ret       = 1'b1;
                ctrl.stack_reg = 1'b1;
                ctrl.uses_rs   = 1'b1;
                ctrl.alu_op    = ALU_ADD;  // Pop increments SP
            end
            default: ctrl = CTRL_NOP;
        endcase
    end

endmodule

// ==== verilog/hazard_detect.sv ====
// Data and PC hazard detection
`timescale 1ns/1ps

module hazard_detect import isa_pkg::*; import pipe_pkg::*; #(
    parameter int HAZARD_DEPTH = 3  // Edges a destination stays blocked
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_valid,
    input  ctrl_t    ctrl,
    input  reg_idx_t rd_idx,
    input  reg_idx_t rs_idx,   // Effective port 1 index
    input  reg_idx_t rt_idx,   // Effective port 2 index
    input  logic     pc_update,
    output logic     data_hazard,
    output logic     pc_hazard
);

    logic [HAZARD_DEPTH-1:0] trk_valid;
    reg_idx_t                trk_idx [HAZARD_DEPTH];
    logic                    rs_hit;
    logic                    rt_hit;
    logic                    issue;

    always_comb begin
        rs_hit = 1'b0;
        rt_hit = 1'b0;
        for (int i = 0; i < HAZARD_DEPTH; i++) begin
            rs_hit |= trk_valid[i] && (trk_idx[i] == rs_idx);
            rt_hit |= trk_valid[i] && (trk_idx[i] == rt_idx);
        end
    end

    // Only operands the instruction really reads
    assign data_hazard = instr_valid && ((ctrl.uses_rs && rs_hit) || (ctrl.uses_rt && rt_hit));
    assign issue       = instr_valid && !data_hazard && !pc_hazard;

    // Tracker shifts every edge, issue or not
    always_ff @(posedge clk) begin
        if (rst) begin
            trk_valid <= '0;
        end else begin
            for (int i = HAZARD_DEPTH - 1; i > 0; i--) begin
                trk_valid[i] <= trk_valid[i-1];
            end
            trk_valid[0] <= issue && ctrl.reg_write;  // Writers only
        end
    end

    always_ff @(posedge clk) begin
        for (int i = HAZARD_DEPTH - 1; i > 0; i--) begin
            trk_idx[i] <= trk_idx[i-1];
        end
        trk_idx[0] <= rd_idx;
    end

    // Held until the PC updater resolves the target
    always_ff @(posedge clk) begin
        if (rst)
            pc_hazard <= 1'b0;
        else if (issue && (ctrl.branch || ctrl.call || ctrl.ret))
            pc_hazard <= 1'b1;
        else if (pc_update)
            pc_hazard <= 1'b0;
    end

endmodule

// ==== verilog/id_stage.sv ====
// Decode stage with ID/EX register
`timescale 1ns/1ps

module id_stage import isa_pkg::*; import pipe_pkg::*; #(
    parameter int HAZARD_DEPTH = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  word_t             instr,
    input  word_t             pc,
    input  logic              pc_update,
    regfile_if.reader         rf,
    output logic              stall,
    output logic              ex_valid,
    output logic              ex_reg_write,
    output logic              ex_mem_write,
    output logic              ex_mem_read,
    output logic              ex_mem_to_reg,
    output logic              ex_alu_src,
    output alu_op_e           ex_alu_op,
    output logic              ex_branch,
    output logic              ex_call,
    output logic              ex_ret,
    output logic              ex_load_half,
    output logic              ex_half_spec,
    output word_t             ex_read_data_1,
    output word_t             ex_read_data_2,
    output word_t             ex_imm,
    output reg_idx_t          ex_dest_reg,
    output logic [2:0]        ex_branch_cond,
    output logic [11:0]       ex_call_target,
    output word_t             ex_pc
);

    ctrl_t    ctrl;
    reg_idx_t rd_field;
    reg_idx_t rs_eff;     // Port 1 index after special selects
    reg_idx_t dest;
    word_t    imm;
    logic     data_hazard;
    logic     pc_hazard;
    logic     issue;

    control_decode dec0 (.opcode(opcode_e'(instr[OPC_MSB:OPC_LSB])), .ctrl(ctrl));

    assign rd_field     = instr[RD_MSB:RD_LSB];
    assign rf.rs_idx    = instr[RS_MSB:RS_LSB];
    assign rf.rt_idx    = ctrl.rt_src ? rd_field : instr[RT_MSB:RT_LSB];  // SW, LHB, LLB
    assign rf.data_reg  = ctrl.data_reg;
    assign rf.stack_reg = ctrl.stack_reg;
    assign rs_eff = ctrl.stack_reg ? STACK_REG :
                    ctrl.data_reg  ? DATA_SEG_REG : instr[RS_MSB:RS_LSB];

    assign dest = (ctrl.call || ctrl.ret) ? STACK_REG : rd_field;
    assign imm  = ctrl.sign_ext_sel ? {{8{instr[IMM8_MSB]}}, instr[IMM8_MSB:IMM8_LSB]}
                                    : {{12{instr[RT_MSB]}}, instr[RT_MSB:RT_LSB]};

    hazard_detect #(.HAZARD_DEPTH(HAZARD_DEPTH)) haz0 (
        .clk, .rst, .instr_valid, .ctrl, .rd_idx(dest), .rs_idx(rs_eff),
        .rt_idx(rf.rt_idx), .pc_update, .data_hazard, .pc_hazard
    );

    assign stall = data_hazard || pc_hazard;  // Fetch holds the word
    assign issue = instr_valid && !stall;

    // Control half, bubble when nothing issues
    always_ff @(posedge clk) begin
        if (rst || !issue) begin
            ex_valid      <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_alu_src    <= 1'b0;
            ex_alu_op     <= ALU_NONE;
            ex_branch     <= 1'b0;
            ex_call       <= 1'b0;
            ex_ret        <= 1'b0;
            ex_load_half  <= 1'b0;
            ex_half_spec  <= 1'b0;
        end else begin
            ex_valid      <= 1'b1;
            ex_reg_write  <= ctrl.reg_write;
            ex_mem_write  <= ctrl.mem_write;
            ex_mem_read   <= ctrl.mem_read;
            ex_mem_to_reg <= ctrl.mem_to_reg;
            ex_alu_src    <= ctrl.alu_src;
            ex_alu_op     <= ctrl.alu_op;
            ex_branch     <= ctrl.branch;
            ex_call       <= ctrl.call;
            ex_ret        <= ctrl.ret;
            ex_load_half  <= ctrl.load_half;
            ex_half_spec  <= ctrl.half_spec;
        end
    end

    // Payload half, only meaningful with ex_valid
    always_ff @(posedge clk) begin
        if (issue) begin
            ex_read_data_1 <= rf.rd_data_1;
            ex_read_data_2 <= rf.rd_data_2;
            ex_imm         <= imm;
            ex_dest_reg    <= dest;
            ex_branch_cond <= instr[COND_MSB:COND_LSB];
            ex_call_target <= instr[TGT_MSB:TGT_LSB];
            ex_pc          <= pc;
        end
    end

endmodule

// ==== verilog/decode_top.sv ====
// Decode stage top level
`timescale 1ns/1ps

module decode_top import isa_pkg::*; import pipe_pkg::*; #(
    parameter word_t SP_RESET     = 16'hFFFF,
    parameter int    HAZARD_DEPTH = 3
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    input  word_t       instr,
    input  word_t       pc,
    input  logic        wb_valid,
    input  reg_idx_t    wb_reg,
    input  word_t       wb_data,
    input  logic        pc_update,
    output logic        stall,
    output logic        ex_valid,
    output logic        ex_reg_write,
    output logic        ex_mem_write,
    output logic        ex_mem_read,
    output logic        ex_mem_to_reg,
    output logic        ex_alu_src,
    output alu_op_e     ex_alu_op,
    output logic        ex_branch,
    output logic        ex_call,
    output logic        ex_ret,
    output logic        ex_load_half,
    output logic        ex_half_spec,
    output word_t       ex_read_data_1,
    output word_t       ex_read_data_2,
    output word_t       ex_imm,
    output reg_idx_t    ex_dest_reg,
    output logic [2:0]  ex_branch_cond,
    output logic [11:0] ex_call_target,
    output word_t       ex_pc
);

    regfile_if rf_bus ();  // Decode to register file reads

    reg_file #(.SP_RESET(SP_RESET)) rf0 (
        .clk, .rst, .rf(rf_bus.file), .wb_valid, .wb_reg, .wb_data
    );

    id_stage #(.HAZARD_DEPTH(HAZARD_DEPTH)) id0 (
        .clk, .rst, .instr_valid, .instr, .pc, .pc_update, .rf(rf_bus.reader),
        .stall, .ex_valid, .ex_reg_write, .ex_mem_write, .ex_mem_read, .ex_mem_to_reg,
        .ex_alu_src, .ex_alu_op, .ex_branch, .ex_call, .ex_ret, .ex_load_half,
        .ex_half_spec, .ex_read_data_1, .ex_read_data_2, .ex_imm, .ex_dest_reg,
        .ex_branch_cond, .ex_call_target, .ex_pc
    );

endmodule

// ==== bench/decode_chk.sv ====
// Decode stage protocol assertions
`timescale 1ns/1ps

module decode_chk import pipe_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    instr_valid,
    input logic    stall,
    input logic    ex_valid,
    input alu_op_e ex_alu_op
);

    int unsigned fail_count = 0;  // Failed assertions so far

    // Hazard state is clear once a reset edge has passed
    stall_after_reset: assert property (@(posedge clk) rst |=> !stall)
        else begin
            fail_count++;
            $error("stall high in the cycle after a reset edge");
        end

    // A stalled word is not taken, so a bubble follows
    no_issue_on_stall: assert property (@(posedge clk) disable iff (rst)
        (instr_valid && stall) |=> !ex_valid)
        else begin
            fail_count++;
            $error("ex_valid high after a stalled instruction");
        end

    bubble_alu_none: assert property (@(posedge clk) disable iff (rst)
        !ex_valid |-> (ex_alu_op == ALU_NONE))
        else begin
            fail_count++;
            $error("alu_op not NONE in a bubble");
        end

endmodule

// ==== bench/decode_tb.sv ====
// Decode stage testbench
`timescale 1ns/1ps

module decode_tb import isa_pkg::*; import pipe_pkg::*; ();

    localparam int          NUM_CYCLES = 600;
    localparam int          HOLD_LIMIT = 40;        // Longest wait for a held word
    localparam int          HAZ        = 3;         // Tracker depth at default parameters
    localparam logic [15:0] SP_INIT    = 16'hFFFF;  // Stack pointer after reset
    localparam logic [31:0] SEED       = 32'd95380;

    logic        clk, rst, instr_valid, wb_valid, pc_update;
    word_t       instr, pc, wb_data;
    reg_idx_t    wb_reg;
    logic        stall, ex_valid, ex_reg_write, ex_mem_write, ex_mem_read, ex_mem_to_reg;
    logic        ex_alu_src, ex_branch, ex_call, ex_ret, ex_load_half, ex_half_spec;
    alu_op_e     ex_alu_op;
    word_t       ex_read_data_1, ex_read_data_2, ex_imm, ex_pc;
    reg_idx_t    ex_dest_reg;
    logic [2:0]  ex_branch_cond;
    logic [11:0] ex_call_target;
    logic [9:0]  ex_ctl;  // Same bit order as m_ctl

    logic [31:0] lfsr;
    word_t       model_regs [16];  // Regfile copy
    logic        trk_v [HAZ];      // Destination tracker
    reg_idx_t    trk_r [HAZ];
    logic        pc_flag;          // Model PC hazard
    logic        pend_valid;       // Word expected on the ex_ outputs
    word_t       pend_ins, pend_pc, pend_d1, pend_d2;
    logic        held;             // Fetch keeps the word
    int          hold_cycles;
    int          value_errs;
    int          timeouts;

    // reg_write mem_write mem_read mem_to_reg alu_src branch call ret load_half half_spec
    logic [9:0]  m_ctl;
    logic [2:0]  m_op;
    reg_idx_t    m_p1, m_p2, m_dest;
    logic        m_p1_chk, m_p1_haz, m_p2_use, m_imm_chk;
    word_t       m_imm;

    decode_top dut0 (.*);

    bind decode_top decode_chk chk0 (
        .clk, .rst, .instr_valid, .stall, .ex_valid, .ex_alu_op
    );

    assign ex_ctl = {ex_reg_write, ex_mem_write, ex_mem_read, ex_mem_to_reg, ex_alu_src,
                     ex_branch, ex_call, ex_ret, ex_load_half, ex_half_spec};

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);  // One step per bit
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        assert (got === exp)
        else begin
            value_errs++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // ALU operation that shares its name with the opcode
    function automatic logic [2:0] alu_op_for(input logic [3:0] opc);
        case (opc)
            4'h0:    return ALU_ADD;
            4'h1:    return ALU_SUB;
            4'h2:    return ALU_AND;
            4'h3:    return ALU_NOR;
            4'h4:    return ALU_SLL;
            4'h5:    return ALU_SRL;
            4'h6:    return ALU_SRA;
            default: return ALU_NONE;
        endcase
    endfunction

    // Decode table for one word
    task automatic decode_model(input word_t ins);
        logic [3:0] opc;
        opc       = ins[15:12];
        m_ctl     = 10'b0;
        m_op      = 3'd7;  // NONE unless the table names an op
        m_p1      = ins[7:4];
        m_p2      = ins[3:0];
        m_p1_chk  = 1'b0;
        m_p1_haz  = 1'b0;
        m_p2_use  = 1'b0;
        m_imm_chk = 1'b0;
        m_imm     = {{8{ins[7]}}, ins[7:0]};  // Byte immediate
        case (opc)
            4'h0, 4'h1, 4'h2, 4'h3: begin
                m_ctl    = 10'b1000000000;
                m_op     = alu_op_for(opc);
                m_p1_chk = 1'b1;
                m_p1_haz = 1'b1;
                m_p2_use = 1'b1;
            end
            4'h4, 4'h5, 4'h6: begin
                m_ctl     = 10'b1000100000;
                m_op      = alu_op_for(opc);
                m_p1_chk  = 1'b1;
                m_p1_haz  = 1'b1;
                m_imm_chk = 1'b1;
                m_imm     = {{12{ins[3]}}, ins[3:0]};  // Shift amount
            end
            4'h8, 4'h9: begin
                m_ctl     = (opc == 4'h8) ? 10'b1011100000 : 10'b0100100000;
                m_op      = 3'd0;
                m_p1      = DATA_SEG_REG;  // Base register without a hazard check
                m_p1_chk  = 1'b1;
                m_p2      = ins[11:8];
                m_p2_use  = (opc == 4'h9);  // Store data
                m_imm_chk = 1'b1;
            end
            4'hA, 4'hB: begin
                m_ctl     = {9'b100000001, opc[0]};  // half_spec for LLB
                m_p2      = ins[11:8];
                m_p2_use  = 1'b1;
                m_imm_chk = 1'b1;
            end
            4'hC: m_ctl = 10'b0000010000;
            4'hD, 4'hE: begin
                m_ctl    = (opc == 4'hD) ? 10'b1000001000 : 10'b1000000100;
                m_op     = (opc == 4'hD) ? 3'd1 : 3'd0;  // SUB on CALL
                m_p1     = STACK_REG;
                m_p1_chk = 1'b1;
                m_p1_haz = 1'b1;
            end
            default: ;
        endcase
        m_dest = (opc == 4'hD || opc == 4'hE) ? STACK_REG : ins[11:8];
    endtask

    function automatic logic blocked(input reg_idx_t idx);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < HAZ; i++) begin
            hit = hit || (trk_v[i] && trk_r[i] == idx);
        end
        return hit;
    endfunction

    // Model state at the clock edge
    task automatic step_model();
        decode_model(pend_ins);
        for (int i = HAZ - 1; i > 0; i--) begin
            trk_v[i] = trk_v[i-1];
            trk_r[i] = trk_r[i-1];
        end
        trk_v[0] = pend_valid && m_ctl[9];  // Writers only
        trk_r[0] = m_dest;
        if (pend_valid && (m_ctl[4] || m_ctl[3] || m_ctl[2]))
            pc_flag = 1'b1;
        else if (pc_update)
            pc_flag = 1'b0;
        if (wb_valid)
            model_regs[wb_reg] = wb_data;
    endtask

    task automatic drive_inputs(input int cyc);
        if (!held) begin
            instr_valid = (cyc == 0) || (rand_bits(2) != 16'h0);
            instr       = rand_bits(16);
            if (cyc == 0)
                instr[15:12] = 4'hD;  // First word is a CALL
            pc = pc + 16'd2;
        end
        wb_valid  = rand_bits(1) != 16'h0;
        wb_reg    = 4'(rand_bits(4));
        wb_data   = rand_bits(16);
        pc_update = pc_flag && (rand_bits(1) != 16'h0);  // Only while a target is open
    endtask

    task automatic check_ex();
        decode_model(pend_ins);
        if (pend_valid) begin
            check_val("ex_valid", 16'(ex_valid), 16'h1);
            check_val("ex_ctrl", 16'(ex_ctl), 16'(m_ctl));
            check_val("ex_alu_op", 16'(ex_alu_op), 16'(m_op));
            if (m_p1_chk) check_val("ex_read_data_1", ex_read_data_1, pend_d1);
            if (m_p2_use) check_val("ex_read_data_2", ex_read_data_2, pend_d2);
            if (m_imm_chk) check_val("ex_imm", ex_imm, m_imm);
            if (m_ctl[9]) check_val("ex_dest_reg", 16'(ex_dest_reg), 16'(m_dest));
            check_val("ex_branch_cond", 16'(ex_branch_cond), 16'(pend_ins[10:8]));
            check_val("ex_call_target", 16'(ex_call_target), 16'(pend_ins[11:0]));
            check_val("ex_pc", ex_pc, pend_pc);
        end else begin
            check_val("ex_valid", 16'(ex_valid), 16'h0);  // Bubble
            check_val("ex_ctrl", 16'(ex_ctl), 16'h0);
            check_val("ex_alu_op", 16'(ex_alu_op), 16'h7);
        end
    endtask

    // Hazard decision for the word on the inputs
    task automatic model_issue();
        logic hit;
        logic exp_stall;
        decode_model(instr);
        hit       = (m_p1_haz && blocked(m_p1)) || (m_p2_use && blocked(m_p2));
        exp_stall = (instr_valid && hit) || pc_flag;
        check_val("stall", 16'(stall), 16'(exp_stall));
        pend_valid  = instr_valid && !exp_stall;
        pend_ins    = instr;
        pend_pc     = pc;
        pend_d1     = model_regs[m_p1];  // Old value on a same-cycle write
        pend_d2     = model_regs[m_p2];
        held        = instr_valid && exp_stall;
        hold_cycles = held ? hold_cycles + 1 : 0;
    endtask

    initial begin
        lfsr        = SEED;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        wb_valid    = 1'b0;
        wb_reg      = '0;
        wb_data     = '0;
        pc_update   = 1'b0;
        pc_flag     = 1'b0;
        pend_valid  = 1'b0;
        pend_ins    = '0;
        held        = 1'b0;
        hold_cycles = 0;
        value_errs  = 0;
        timeouts    = 0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = (i == 15) ? SP_INIT : 16'h0;
        end
        for (int i = 0; i < HAZ; i++) begin
            trk_v[i] = 1'b0;
            trk_r[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        #8;
        check_val("stall", 16'(stall), 16'h0);
        check_val("ex_valid", 16'(ex_valid), 16'h0);
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            step_model();
            #2;
            drive_inputs(cyc);
            #8;  // Outputs settled
            check_ex();
            if (cyc == 1) begin
                check_val("ex_read_data_1", ex_read_data_1, SP_INIT);  // CALL sees reset SP
                check_val("ex_dest_reg", 16'(ex_dest_reg), 16'hF);
            end
            model_issue();
            if (hold_cycles > HOLD_LIMIT) begin
                $display("Timeout: word %h at pc %h not taken within %0d cycles",
                         instr, pc, HOLD_LIMIT);
                timeouts++;
                break;
            end
        end
        $display("Errors: %0d value, %0d timeout, %0d assertion",
                 value_errs, timeouts, dut0.chk0.fail_count);
        if (value_errs + timeouts + dut0.chk0.fail_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/regfile_if.sv
verilog/reg_file.sv
verilog/control_decode.sv
verilog/hazard_detect.sv
verilog/id_stage.sv
verilog/decode_top.sv
bench/decode_chk.sv
bench/decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the decode stage testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
